// File: dv/sdram_trace.txt
# columns: op addr data mask expected, all hex; mask bit 1 blocks that byte
# op: 0 write, 1 read, 2 dl on, 3 dl off, 4 prog write, 5 idle (addr clocks, data refresh_en), 6 refresh rose
0 001204 1234 0 0
0 001205 5678 0 0
0 001205 abcd 1 0
0 001204 ef99 2 0
1 001204 0000 0 1299ab78
0 000a10 0000 0 0
0 000a11 0000 0 0
2 000000 0000 0 0
4 000a10 003c 1 0
4 000a11 00c3 2 0
3 000000 0000 0 1
1 000a10 0000 0 3c0000c3
5 000014 0000 0 0
6 000000 0000 0 0
5 000014 0001 0 0
6 000000 0000 0 1
5 000002 0001 0 0
1 001204 0000 0 1299ab78
0 001206 0f0f 0 0
5 000004 0000 0 0

// File: compile.f
hdl/sdram_pkg.sv
hdl/sdram_init_seq.sv
hdl/sdram_cycle_engine.sv
hdl/sdram_ctrl_top.sv
dv/sdram_model.sv
dv/tb_sdram_ctrl.sv

// File: dv/tb_sdram_ctrl.sv
// trace-driven testbench; run from the project root so dv/sdram_trace.txt is found, fields in hex
`timescale 1ns/1ps

module tb_sdram_ctrl;

    localparam int INIT_TIMEOUT = 6000; // clocks, power-up wait plus init padding
    localparam int WAIT_TIMEOUT = 64;   // clocks per handshake wait

    logic        clk = 1'b0;
    logic        rst;
    logic        read_req, sdram_rnw, refresh_en, downloading, prog_we, prog_rd;
    logic [21:0] sdram_addr, prog_addr;
    logic [15:0] data_write;
    logic [1:0]  sdram_wrmask, prog_mask;
    logic [7:0]  prog_data;
    logic        sdram_ack, data_rdy, loop_rst;
    logic [31:0] data_read;
    wire  [15:0] sdram_dq;
    logic [12:0] sdram_a;
    logic [1:0]  sdram_ba;
    logic        sdram_dqml, sdram_dqmh, sdram_cke;
    logic        sdram_n_we, sdram_n_cas, sdram_n_ras, sdram_n_cs;

    int errors = 0;
    int ref_start = 0; // refresh count when the last idle stretch began

    always #10 clk = ~clk; // 50 MHz

    sdram_ctrl_top DUT (.*);

    sdram_model mem_model (
        .clk   (clk),
        .dq    (sdram_dq),
        .a     (sdram_a),
        .dqml  (sdram_dqml),
        .dqmh  (sdram_dqmh),
        .n_we  (sdram_n_we),
        .n_cas (sdram_n_cas),
        .n_ras (sdram_n_ras),
        .n_cs  (sdram_n_cs)
    );

    task automatic check_value(input string name, input logic [31:0] actual,
                               input logic [31:0] expected);
        if (actual !== expected) begin
            errors++;
            $display("[ERROR] %s: got %h, expected %h", name, actual, expected);
        end
    endtask

    task automatic abort_run(input string why);
        $display("%s", why);
        $display("Test failed");
        $finish;
    endtask

    // one request, game or program write, through ack and data_rdy
    task automatic run_access(input logic prog, input logic rnw, input logic [21:0] addr,
                              input logic [15:0] data, input logic [1:0] mask,
                              input logic [31:0] expected);
        int cnt;
        int extra_ack;
        cnt       = 0;
        extra_ack = 0;
        @(posedge clk);
        if (prog) begin
            prog_we   <= 1'b1; // one-cycle strobe
            prog_addr <= addr;
            prog_data <= data[7:0];
            prog_mask <= mask;
            @(posedge clk);
            prog_we <= 1'b0;
        end else begin
            read_req     <= 1'b1; // held until ack
            sdram_addr   <= addr;
            sdram_rnw    <= rnw;
            data_write   <= data;
            sdram_wrmask <= mask;
        end
        @(posedge clk);
        while (!sdram_ack && cnt < WAIT_TIMEOUT) begin
            cnt++;
            @(posedge clk);
        end
        if (!sdram_ack)
            abort_run("timeout while waiting for sdram_ack");
        check_value("data_rdy at ack", data_rdy, 1'b0); // ack comes first
        read_req <= 1'b0;
        cnt = 0;
        @(posedge clk);
        check_value("sdram_ack width", sdram_ack, 1'b0);
        while (!data_rdy && cnt < WAIT_TIMEOUT) begin
            if (sdram_ack)
                extra_ack++;
            cnt++;
            @(posedge clk);
        end
        if (!data_rdy)
            abort_run("timeout while waiting for data_rdy");
        check_value("extra sdram_ack pulses", extra_ack, 0);
        if (rnw && !prog)
            check_value("data_read", data_read, expected);
        @(posedge clk);
        check_value("data_rdy width", data_rdy, 1'b0);
        check_value("sdram_dq idle", sdram_dq, 16'h0000); // bus back to held low
    endtask

    // level change, then wait for the burst reload to reach the device
    task automatic switch_download(input logic on, input logic [31:0] expected);
        int cnt;
        int start;
        cnt = 0;
        @(posedge clk);
        downloading <= on;
        start = mem_model.mode_cnt;
        while (mem_model.mode_cnt == start && cnt < WAIT_TIMEOUT) begin
            cnt++;
            @(posedge clk);
        end
        if (mem_model.mode_cnt == start)
            abort_run("timeout while waiting for the mode load after a download change");
        check_value("mode burst bit", mem_model.mode_word[0], expected);
    endtask

    task automatic idle_stretch(input int cycles, input logic en);
        @(posedge clk);
        refresh_en <= en;
        ref_start = mem_model.ref_cnt;
        repeat (cycles) @(posedge clk);
    endtask

    initial begin
        int              fd;
        int              n;
        int              cnt;
        logic [31:0]     op, addr, data, mask, expv;
        logic [8*96-1:0] line;
        rst          = 1'b1;
        read_req     = 1'b0;
        sdram_addr   = '0;
        sdram_rnw    = 1'b1;
        data_write   = '0;
        sdram_wrmask = '0;
        refresh_en   = 1'b0;
        downloading  = 1'b0;
        prog_we      = 1'b0;
        prog_rd      = 1'b0;
        prog_addr    = '0;
        prog_data    = '0;
        prog_mask    = '0;
        cnt          = 0;
        fd = $fopen("dv/sdram_trace.txt", "r");
        if (fd == 0)
            abort_run("could not open the trace file dv/sdram_trace.txt");
        repeat (2) @(posedge clk);
        rst <= 1'b0;
        @(posedge clk);
        check_value("loop_rst after reset", loop_rst, 1'b1);
        check_value("sdram_ack after reset", sdram_ack, 1'b0);
        check_value("data_rdy after reset", data_rdy, 1'b0);
        while (loop_rst && cnt < INIT_TIMEOUT) begin
            cnt++;
            @(posedge clk);
        end
        if (loop_rst)
            abort_run("timeout while waiting for loop_rst to fall");
        check_value("init mode loads", mem_model.mode_cnt, 1);
        check_value("init burst bit", mem_model.mode_word[0], 1'b1);
        check_value("precharge-all count", mem_model.pre_all_cnt, 2);
        check_value("sdram_ba", sdram_ba, 2'b00);   // bank 0 only
        check_value("sdram_cke", sdram_cke, 1'b1);
        check_value("sdram_dq idle", sdram_dq, 16'h0000);
        while ($fgets(line, fd) != 0) begin
            n = $sscanf(line, "%h %h %h %h %h", op, addr, data, mask, expv);
            if (n == 5) begin // comment and blank lines fall through
                case (op)
                    0: run_access(1'b0, 1'b0, addr[21:0], data[15:0], mask[1:0], expv);
                    1: run_access(1'b0, 1'b1, addr[21:0], data[15:0], mask[1:0], expv);
                    2: switch_download(1'b1, expv);
                    3: switch_download(1'b0, expv);
                    4: run_access(1'b1, 1'b0, addr[21:0], data[15:0], mask[1:0], expv);
                    5: idle_stretch(addr, data[0]);
                    6: check_value("refresh count rose", mem_model.ref_cnt != ref_start, expv);
                    default: begin
                        errors++;
                        $display("unknown opcode %0h in the trace file", op);
                    end
                endcase
            end
        end
        $fclose(fd);
        $display("errors: %0d", errors);
        if (errors == 0)
            $display("Test completed successfully");
        else
            $display("Test failed");
        $finish;
    end

endmodule

// File: dv/sdram_model.sv
// bank 0 only, rows alias above bit 4; read data shows in the two slots after the column command
`timescale 1ns/1ps

module sdram_model (
    input  logic        clk,
    inout  wire  [15:0] dq,
    input  logic [12:0] a,
    input  logic        dqml,
    input  logic        dqmh,
    input  logic        n_we,
    input  logic        n_cas,
    input  logic        n_ras,
    input  logic        n_cs
);

    logic [15:0] mem [0:16383]; // {row[4:0], col}
    logic [12:0] row_q;          // open row
    logic [15:0] drv_data;
    logic        drv_en;
    logic        rd_left;        // second burst word still due
    logic [13:0] next_idx;
    logic [13:0] idx;
    logic [3:0]  cmd;

    // seen by the testbench
    int          ref_cnt;
    int          pre_all_cnt;
    int          mode_cnt;
    logic [12:0] mode_word;

    assign cmd = {n_cs, n_ras, n_cas, n_we};
    assign idx = {row_q[4:0], a[8:0]};
    assign dq  = drv_en ? drv_data : 16'hzzzz; // device owns dq only while bursting

    initial begin
        for (int i = 0; i < 16384; i++)
            mem[i] = 16'h5a3c ^ (i[15:0] * 16'h0107); // odd multiplier, every address bit counts
        row_q       = '0;
        drv_en      = 1'b0;
        drv_data    = '0;
        rd_left     = 1'b0;
        next_idx    = '0;
        ref_cnt     = 0;
        pre_all_cnt = 0;
        mode_cnt    = 0;
        mode_word   = '0;
    end

    always @(posedge clk) begin
        if (rd_left) begin
            drv_data <= mem[next_idx]; // second word of a two-word burst
            rd_left  <= 1'b0;
        end else begin
            drv_en <= 1'b0;
        end
        case (cmd)
            sdram_pkg::activate: row_q <= a;
            sdram_pkg::write: begin
                // single-location write, dqm high blocks the byte
                if (!dqml)
                    mem[idx][7:0] <= dq[7:0];
                if (!dqmh)
                    mem[idx][15:8] <= dq[15:8];
            end
            sdram_pkg::read: begin
                drv_en   <= 1'b1;
                drv_data <= mem[idx];
                rd_left  <= mode_word[0];                    // burst length 2
                next_idx <= {row_q[4:0], a[8:1], ~a[0]};     // sequential wrap in the pair
            end
            sdram_pkg::precharge: begin
                if (a[10])
                    pre_all_cnt <= pre_all_cnt + 1;
            end
            sdram_pkg::auto_refresh: ref_cnt <= ref_cnt + 1;
            sdram_pkg::load_mode: begin
                mode_word <= a;
                mode_cnt  <= mode_cnt + 1;
            end
            default: ;
        endcase
    end

endmodule

// File: hdl/sdram_ctrl_top.sv
// single 16-bit sdram on bank 0 with cke tied high; dq held low when nobody drives it
`timescale 1ns/1ps

module sdram_ctrl_top (
    input  logic        clk,
    input  logic        rst,
    // game side
    input  logic        read_req,
    input  logic [21:0] sdram_addr,
    input  logic        sdram_rnw,
    input  logic [15:0] data_write,
    input  logic [1:0]  sdram_wrmask,
    input  logic        refresh_en,
    output logic        sdram_ack,
    output logic        data_rdy,
    output logic [31:0] data_read,
    output logic        loop_rst,
    // download side
    input  logic        downloading,
    input  logic        prog_we,
    input  logic        prog_rd,
    input  logic [21:0] prog_addr,
    input  logic [7:0]  prog_data,
    input  logic [1:0]  prog_mask,
    // sdram pins
    inout  wire  [15:0] sdram_dq,
    output logic [12:0] sdram_a,
    output logic        sdram_dqml,
    output logic        sdram_dqmh,
    output logic        sdram_n_we,
    output logic        sdram_n_cas,
    output logic        sdram_n_ras,
    output logic        sdram_n_cs,
    output logic [1:0]  sdram_ba,
    output logic        sdram_cke
);

    sdram_pkg::sdram_cmd_e init_cmd, eng_cmd, cmd;
    logic [12:0] init_a, eng_a;
    logic        init_done;
    logic [1:0]  eng_dqm;
    logic [15:0] dq_out, dq_in;
    logic        dq_oe, dq_hold;

    sdram_init_seq u_init (
        .clk       (clk),
        .rst       (rst),
        .init_cmd  (init_cmd),
        .init_a    (init_a),
        .init_done (init_done)
    );

    sdram_cycle_engine u_engine (
        .clk          (clk),
        .rst          (rst),
        .init_done    (init_done),
        .read_req     (read_req),
        .sdram_addr   (sdram_addr),
        .sdram_rnw    (sdram_rnw),
        .data_write   (data_write),
        .sdram_wrmask (sdram_wrmask),
        .refresh_en   (refresh_en),
        .sdram_ack    (sdram_ack),
        .data_rdy     (data_rdy),
        .data_read    (data_read),
        .downloading  (downloading),
        .prog_we      (prog_we),
        .prog_rd      (prog_rd),
        .prog_addr    (prog_addr),
        .prog_data    (prog_data),
        .prog_mask    (prog_mask),
        .eng_cmd      (eng_cmd),
        .eng_a        (eng_a),
        .eng_dqm      (eng_dqm),
        .dq_out       (dq_out),
        .dq_oe        (dq_oe),
        .dq_hold      (dq_hold),
        .dq_in        (dq_in)
    );

    // both sources are registered, the mux stays shallow
    assign cmd     = init_done ? eng_cmd : init_cmd;
    assign sdram_a = init_done ? eng_a : init_a;
    assign {sdram_n_cs, sdram_n_ras, sdram_n_cas, sdram_n_we} = cmd;

    assign sdram_dqml = eng_dqm[0]; // mask bit 1 blocks the byte
    assign sdram_dqmh = eng_dqm[1];

    // write data, else held low, else released for read data
    assign sdram_dq = dq_oe ? dq_out : (dq_hold ? 16'h0000 : 16'hzzzz);
    assign dq_in    = sdram_dq;

    assign sdram_ba  = 2'b00; // no interleaving
    assign sdram_cke = 1'b1;
    assign loop_rst  = ~init_done; // game core waits for the sdram
endmodule

// File: hdl/sdram_cycle_engine.sv
// one access in flight, bank 0 only with auto-precharge; game requests wait while downloading
`timescale 1ns/1ps

module sdram_cycle_engine (
    input  logic                              clk,
    input  logic                              rst,
    input  logic                              init_done,
    // game side
    input  logic                              read_req,
    input  logic [21:0]                       sdram_addr,
    input  logic                              sdram_rnw,
    input  logic [15:0]                       data_write,
    input  logic [1:0]                        sdram_wrmask,
    input  logic                              refresh_en,
    output logic                              sdram_ack,
    output logic                              data_rdy,
    output logic [31:0]                       data_read,
    // rom download side
    input  logic                              downloading,
    input  logic                              prog_we,
    input  logic                              prog_rd,
    input  logic [21:0]                       prog_addr,
    input  logic [7:0]                        prog_data,
    input  logic [1:0]                        prog_mask,
    // towards the pins
    output sdram_pkg::sdram_cmd_e             eng_cmd,
    output logic [sdram_pkg::ROW_W-1:0]       eng_a,
    output logic [1:0]                        eng_dqm,
    output logic [15:0]                       dq_out,
    output logic                              dq_oe,
    output logic                              dq_hold,
    input  logic [15:0]                       dq_in
);

    sdram_pkg::cycle_state_e state;

    logic prog_we_q, prog_rd_q;  // registered strobes
    logic dl_q, dl_last;         // registered downloading level and its previous value
    logic pend_we, pend_rd;      // strobe seen, access not started yet
    logic set_burst, burst_mode; // mode reload request, 1 = two-word bursts

    logic wr_cycle, rd_cycle, ref_cycle;
    logic rdy_q;                 // access finished, before the output register

    logic [sdram_pkg::REFRESH_IDLE-1:0] refresh_sr; // idle slot counter, one bit per slot
    logic                               refresh_ok;

    logic [sdram_pkg::COL_W-1:0] col_addr;
    logic [sdram_pkg::ROW_W-1:0] col_word; // column command address
    logic [1:0]                  wr_mask;
    logic [15:0]                 dq_hi, dq_lo;  // first and second read word

    logic        take_mode, take_prog, take_game, take_ref;
    logic [21:0] acc_addr;

    assign refresh_ok = refresh_sr[sdram_pkg::REFRESH_IDLE-1];
    assign dq_oe      = wr_cycle; // drive write data until st_cap0

    // st_cmd decisions, mode reload first, then download, game, refresh
    always_comb begin
        take_mode = 1'b0;
        take_prog = 1'b0;
        take_game = 1'b0;
        take_ref  = 1'b0;
        if (init_done && state == sdram_pkg::st_cmd) begin
            if (set_burst)
                take_mode = 1'b1;
            else if (pend_we || pend_rd)
                take_prog = 1'b1;
            else if (read_req && !dl_q)
                take_game = 1'b1;
            else if (refresh_ok)
                take_ref = 1'b1;
        end
        acc_addr = take_prog ? prog_addr : sdram_addr;
    end

    // column address with auto-precharge
    always_comb begin
        col_word = '0;
        col_word[sdram_pkg::COL_W-1:0] = col_addr;
        col_word[sdram_pkg::AP_BIT]    = 1'b1;
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            prog_we_q <= 1'b0;
            prog_rd_q <= 1'b0;
            dl_q      <= 1'b0;
            dl_last   <= 1'b0;
        end else begin
            prog_we_q <= downloading & prog_we; // strobes only count while downloading
            prog_rd_q <= downloading & prog_rd;
            dl_q      <= downloading;
            dl_last   <= dl_q;
        end
    end

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            state      <= sdram_pkg::st_cmd;
            eng_cmd    <= sdram_pkg::nop;
            eng_a      <= '0;
            eng_dqm    <= 2'b00;
            sdram_ack  <= 1'b0;
            rdy_q      <= 1'b0;
            wr_cycle   <= 1'b0;
            rd_cycle   <= 1'b0;
            ref_cycle  <= 1'b0;
            dq_hold    <= 1'b1; // keep dq low while idle
            refresh_sr <= '0;
            set_burst  <= 1'b0;
            burst_mode <= 1'b1; // init leaves two-word bursts
            pend_we    <= 1'b0;
            pend_rd    <= 1'b0;
        end else begin
            if (init_done) begin
                eng_cmd <= sdram_pkg::nop;
                rdy_q   <= 1'b0; // one clock pulse
                case (state)
                    sdram_pkg::st_cmd: begin
                        wr_cycle  <= 1'b0;
                        rd_cycle  <= 1'b0;
                        ref_cycle <= 1'b0;
                        dq_hold   <= 1'b1;
                        eng_dqm   <= 2'b00;
                        if (take_mode) begin
                            eng_cmd   <= sdram_pkg::load_mode;
                            eng_a     <= sdram_pkg::MODE_BASE |
                                         {{(sdram_pkg::ROW_W-1){1'b0}}, burst_mode};
                            set_burst <= 1'b0;
                            state     <= sdram_pkg::st_cap1; // one nop slot, then back
                        end else if (take_prog || take_game) begin
                            eng_cmd    <= sdram_pkg::activate;
                            eng_a      <= acc_addr[21:sdram_pkg::COL_W]; // row
                            sdram_ack  <= 1'b1;
                            wr_cycle   <= take_prog ? pend_we : !sdram_rnw;
                            rd_cycle   <= take_prog ? !pend_we : sdram_rnw;
                            refresh_sr <= '0;
                            if (take_prog) begin
                                pend_we <= 1'b0;
                                pend_rd <= 1'b0;
                            end
                            state <= sdram_pkg::st_rw;
                        end else if (take_ref) begin
                            eng_cmd    <= sdram_pkg::auto_refresh;
                            ref_cycle  <= 1'b1;
                            refresh_sr <= '0;
                            state      <= sdram_pkg::st_rw;
                        end else if (refresh_en) begin
                            // count one more idle slot
                            refresh_sr <= {refresh_sr[sdram_pkg::REFRESH_IDLE-2:0], 1'b1};
                        end else begin
                            refresh_sr <= '0;
                        end
                    end
                    sdram_pkg::st_rw: begin
                        sdram_ack <= 1'b0;
                        if (!ref_cycle) begin
                            eng_a   <= col_word;
                            eng_dqm <= wr_cycle ? wr_mask : 2'b00; // reads take both bytes
                            eng_cmd <= wr_cycle ? sdram_pkg::write : sdram_pkg::read;
                        end
                        state <= sdram_pkg::st_gap;
                    end
                    sdram_pkg::st_gap: begin
                        if (rd_cycle)
                            dq_hold <= 1'b0; // device drives dq next
                        state <= sdram_pkg::st_cap0;
                    end
                    sdram_pkg::st_cap0: begin
                        eng_dqm <= 2'b00;
                        if (wr_cycle) begin
                            rdy_q    <= 1'b1; // write done
                            wr_cycle <= 1'b0;
                            state    <= sdram_pkg::st_cmd;
                        end else if (ref_cycle) begin
                            state <= sdram_pkg::st_cmd; // refresh needs four slots
                        end else begin
                            state <= sdram_pkg::st_cap1;
                        end
                    end
                    sdram_pkg::st_cap1: begin
                        if (rd_cycle) begin
                            rdy_q   <= 1'b1; // both words in
                            dq_hold <= 1'b1;
                        end
                        state <= sdram_pkg::st_cmd;
                    end
                    default: begin
                        state <= sdram_pkg::st_cmd;
                    end
                endcase
            end
            // level change wins over the clear above
            if (dl_q != dl_last) begin
                set_burst  <= 1'b1;
                burst_mode <= !dl_q; // single words while downloading
            end
            if (prog_we_q)
                pend_we <= 1'b1;
            if (prog_rd_q)
                pend_rd <= 1'b1;
        end
    end

    // access payload and read capture
    always_ff @(posedge clk) begin
        if (take_prog || take_game) begin
            col_addr <= acc_addr[sdram_pkg::COL_W-1:0];
            dq_out   <= take_prog ? {prog_data, prog_data} : data_write; // byte on both halves
            wr_mask  <= take_prog ? prog_mask : sdram_wrmask;
        end
        if (rd_cycle && state == sdram_pkg::st_cap0)
            dq_hi <= dq_in; // even column
        if (rd_cycle && state == sdram_pkg::st_cap1)
            dq_lo <= dq_in; // next column
        data_read <= {dq_hi, dq_lo};
    end

    // output stage, data_rdy one clock behind rdy_q
    always_ff @(posedge clk or posedge rst) begin
        if (rst)
            data_rdy <= 1'b0;
        else
            data_rdy <= rdy_q;
    end

endmodule

// File: hdl/sdram_init_seq.sv
// power-up sequence only; init_done stays high until the next reset, burst length left at 2
`timescale 1ns/1ps

module sdram_init_seq (
    input  logic                    clk,
    input  logic                    rst,
    output sdram_pkg::sdram_cmd_e   init_cmd,
    output logic [12:0]             init_a,
    output logic                    init_done
);

    logic [13:0]             wait_cnt; // nop clocks left before the next step
    sdram_pkg::init_step_e   step;

    // precharge-all address word
    logic [12:0] pre_all;
    assign pre_all = 13'd1 << sdram_pkg::AP_BIT;

    always_ff @(posedge clk or posedge rst) begin
        if (rst) begin
            wait_cnt  <= sdram_pkg::INIT_WAIT; // long power-up wait first
            step      <= sdram_pkg::in_pre0;
            init_cmd  <= sdram_pkg::nop;
            init_a    <= '0;
            init_done <= 1'b0;
        end else begin
            init_cmd <= sdram_pkg::nop; // default, commands last one clock
            if (wait_cnt != 14'd0) begin
                wait_cnt <= wait_cnt - 14'd1; // padding
            end else begin
                case (step)
                    sdram_pkg::in_pre0: begin
                        init_cmd <= sdram_pkg::precharge;
                        init_a   <= pre_all;
                        wait_cnt <= sdram_pkg::T_PRE;
                        step     <= sdram_pkg::in_ref;
                    end
                    sdram_pkg::in_ref: begin
                        init_cmd <= sdram_pkg::auto_refresh;
                        wait_cnt <= sdram_pkg::T_REF;
                        step     <= sdram_pkg::in_mode;
                    end
                    sdram_pkg::in_mode: begin
                        // normal operation reads two words
                        init_cmd <= sdram_pkg::load_mode;
                        init_a   <= sdram_pkg::MODE_BASE | 13'd1;
                        wait_cnt <= sdram_pkg::T_MRD;
                        step     <= sdram_pkg::in_pre1;
                    end
                    sdram_pkg::in_pre1: begin
                        init_cmd <= sdram_pkg::precharge;
                        init_a   <= pre_all;
                        wait_cnt <= sdram_pkg::T_PRE;
                        step     <= sdram_pkg::in_done;
                    end
                    sdram_pkg::in_done: begin
                        init_done <= 1'b1; // hand the bus to the engine
                    end
                    default: begin
                        step <= sdram_pkg::in_done;
                    end
                endcase
            end
        end
    end

endmodule

// File: hdl/sdram_pkg.sv
// shared by all sdram files; assumes a 50 MHz clock and a 16-bit SDR device in bank 0 only
package sdram_pkg;

    // sdram command bus {n_cs, n_ras, n_cas, n_we}
    typedef enum logic [3:0] {
        load_mode    = 4'b0000,
        auto_refresh = 4'b0001,
        precharge    = 4'b0010,
        activate     = 4'b0011,
        write        = 4'b0100,
        read         = 4'b0101,
        burst_stop   = 4'b0110, // burst terminate
        nop          = 4'b0111,
        inhibit      = 4'b1000  // chip deselected
    } sdram_cmd_e;

    // access engine slots, one per clock
    typedef enum logic [2:0] {
        st_cmd,  // activate, refresh or mode load
        st_rw,   // column command
        st_gap,  // cas latency filler
        st_cap0, // first read word, end of write and refresh
        st_cap1  // second read word, tail of a mode load
    } cycle_state_e;

    // power-up steps after the long wait
    typedef enum logic [2:0] {
        in_pre0,
        in_ref,
        in_mode,
        in_pre1,
        in_done
    } init_step_e;

    // power-up wait, 100us at 50MHz
    localparam logic [13:0] INIT_WAIT = 14'd5000;

    // nop padding after each init command
    localparam logic [13:0] T_PRE = 14'd2;  // precharge to next cmd
    localparam logic [13:0] T_REF = 14'd11; // covers trfc
    localparam logic [13:0] T_MRD = 14'd3;  // mode load settle

    // mode word: single-location writes (A9), CL=2, sequential bursts
    // bit 0 picks burst length, 0 = one word, 1 = two words
    localparam logic [12:0] MODE_BASE = 13'b00_1_00_010_0_000;

    // A10 is both precharge-all and auto-precharge on column commands
    localparam int AP_BIT = 10;

    // idle st_cmd slots before an auto refresh goes out
    localparam int REFRESH_IDLE = 3;

    // word address = {row, col}
    localparam int ROW_W = 13;
    localparam int COL_W = 9;

endpackage
